//--- src.f
design/cache_pkg.sv
design/cache_ctrl.sv
design/cache_array.sv
design/mem_port.sv
design/cache_top.sv
verif/mem_model.sv
verif/tb_cache.sv

//--- Bender.yml
package:
  name: cache

sources:
  # design sources in compile order
  - files:
      - design/cache_pkg.sv
      - design/cache_ctrl.sv
      - design/cache_array.sv
      - design/mem_port.sv
      - design/cache_top.sv

  # simulation only
  - target: test
    files:
      - verif/mem_model.sv
      - verif/tb_cache.sv

//--- verif/tb_cache.sv
module tb_cache;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RANDOM  = 300;
    localparam int NUM_REQS    = NUM_RANDOM + 5;
    // dirty miss with the longest memory delay plus the idle gap
    localparam int WORST_CYCLES = 24;
    localparam int WATCHDOG_CYCLES = NUM_REQS * WORST_CYCLES + 100;

    logic        clk;
    logic        rst;
    logic        cpu_req_valid;
    logic [31:0] cpu_req_addr;
    logic        cpu_req_wr;
    logic [31:0] cpu_req_wdata;
    logic        cpu_req_ready;
    logic [31:0] cpu_req_data;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;
    logic [31:0] mem_req_wdata;
    logic        mem_req_wr;
    logic        mem_req_ready;
    logic [31:0] mem_req_data;
    logic [1:0]  mem_delay;

    logic [31:0] lfsr;
    logic [31:0] shadow [logic [31:0]];
    logic        line_valid [16];
    logic        line_dirty [16];
    logic [11:0] line_tag [16];

    // expectations for the request in flight
    logic        req_seen;
    logic        accept;
    logic        exp_hit;
    int          exp_xfers;
    logic [31:0] exp_data;
    logic [31:0] exp_wb_addr;
    logic [31:0] exp_wb_data;
    int          mem_xfers;
    int          errors;
    int          n_reqs;

    cache_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_wr    (cpu_req_wr),
        .cpu_req_wdata (cpu_req_wdata),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_wr    (mem_req_wr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    mem_model u_mem_model (
        .clk           (clk),
        .rst           (rst),
        .delay         (mem_delay),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_wr    (mem_req_wr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (shadow.exists(addr))
        begin
            return shadow[addr];
        end
        return ~addr;
    endfunction

    // memory transfers seen during the current request
    always @(posedge clk)
    begin
        if (mem_req_valid && mem_req_ready)
        begin
            mem_xfers <= mem_xfers + 1;
        end
        else if (cpu_req_ready)
        begin
            mem_xfers <= 0;
        end
    end

    task automatic run_request(input logic [15:0] addr, input logic wr, input logic [31:0] wdata);
        logic [3:0]  idx;
        logic [11:0] tag;
        idx = addr[3:0];
        tag = addr[15:4];
        exp_hit = line_valid[idx] && (line_tag[idx] == tag);
        exp_xfers = 1;
        if (exp_hit)
        begin
            exp_xfers = 0;
        end
        else if (line_valid[idx] && line_dirty[idx])
        begin
            exp_xfers   = 2;
            exp_wb_addr = {16'h0, line_tag[idx], addr[3:0]};
            exp_wb_data = shadow_read(exp_wb_addr);
        end
        exp_data      = wr ? wdata : shadow_read({16'h0, addr});
        cpu_req_addr  = {16'h0, addr};
        cpu_req_wr    = wr;
        cpu_req_wdata = wdata;
        cpu_req_valid = 1'b1;
        req_seen      = 1'b1;
        accept        = 1'b1;
        @(negedge clk);
        accept = 1'b0;
        while (!cpu_req_ready)
        begin
            @(negedge clk);
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
        line_dirty[idx] = wr || (exp_hit && line_dirty[idx]);
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tag;
        if (wr)
        begin
            shadow[{16'h0, addr}] = wdata;
        end
        n_reqs++;
    endtask

    // quiet ports until the first request
    assert property (@(negedge clk) !req_seen |-> !cpu_req_ready && !mem_req_valid)
        else begin
            errors++;
            $display("ERR cpu_req_ready=%h mem_req_valid=%h before first request",
                     $sampled(cpu_req_ready), $sampled(mem_req_valid));
        end

    assert property (@(posedge clk) disable iff (rst)
        accept && exp_hit |=> cpu_req_ready && !mem_req_valid)
        else begin
            errors++;
            $display("ERR cpu_req_ready=%h mem_req_valid=%h on hit, expected 1 and 0",
                     $sampled(cpu_req_ready), $sampled(mem_req_valid));
        end

    assert property (@(posedge clk) disable iff (rst) accept && !exp_hit |=> !cpu_req_ready)
        else begin
            errors++;
            $display("ERR cpu_req_ready=%h on miss, expected 0", $sampled(cpu_req_ready));
        end

    assert property (@(posedge clk) disable iff (rst) cpu_req_ready |-> cpu_req_data == exp_data)
        else begin
            errors++;
            $display("ERR cpu_req_data got %h expected %h", $sampled(cpu_req_data),
                     $sampled(exp_data));
        end

    assert property (@(posedge clk) disable iff (rst) cpu_req_ready |-> mem_xfers == exp_xfers)
        else begin
            errors++;
            $display("ERR mem_xfers got %h expected %h", $sampled(mem_xfers),
                     $sampled(exp_xfers));
        end

    assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_valid) |-> mem_req_wr == (exp_xfers == 2 && mem_xfers == 0))
        else begin
            errors++;
            $display("ERR mem_req_wr=%h expected %h at transfer %h", $sampled(mem_req_wr),
                     $sampled(exp_xfers == 2 && mem_xfers == 0), $sampled(mem_xfers));
        end

    assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_valid) |-> mem_req_addr == (mem_req_wr ? exp_wb_addr : cpu_req_addr))
        else begin
            errors++;
            $display("ERR mem_req_addr=%h wr=%h, write-back %h request %h",
                     $sampled(mem_req_addr), $sampled(mem_req_wr),
                     $sampled(exp_wb_addr), $sampled(cpu_req_addr));
        end

    assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_valid) && mem_req_wr |-> mem_req_wdata == exp_wb_data)
        else begin
            errors++;
            $display("ERR mem_req_wdata got %h expected %h", $sampled(mem_req_wdata),
                     $sampled(exp_wb_data));
        end

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
            $stable(mem_req_wdata) && $stable(mem_req_wr))
        else begin
            errors++;
            $display("ERR mem_req_valid=%h addr=%h wdata=%h wr=%h changed while stalled",
                     $sampled(mem_req_valid), $sampled(mem_req_addr),
                     $sampled(mem_req_wdata), $sampled(mem_req_wr));
        end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all requests completed");
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wr    = 1'b0;
        cpu_req_wdata = '0;
        mem_delay     = '0;
        lfsr          = 32'h433ec859;
        req_seen      = 1'b0;
        accept        = 1'b0;
        exp_hit       = 1'b0;
        exp_xfers     = 0;
        exp_data      = '0;
        exp_wb_addr   = '0;
        exp_wb_data   = '0;
        mem_xfers     = 0;
        errors        = 0;
        n_reqs        = 0;
        for (int i = 0; i < 16; i++)
        begin
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
            line_tag[i]   = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        // clean miss then a hit on the filled line
        run_request(16'h0005, 1'b0, '0);
        run_request(16'h0005, 1'b0, '0);
        // write hit then its eviction under a slow memory
        run_request(16'h0005, 1'b1, 32'hcafe0005);
        mem_delay = 2'd3;
        run_request(16'h0015, 1'b0, '0);
        run_request(16'h0005, 1'b0, '0);

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            mem_delay = 2'(rand_bits(2));
            run_request(16'(rand_bits(6)), 1'(rand_bits(1)), rand_bits(32));
        end

        repeat (2) @(negedge clk);
        $display("checks failed: %0d, requests completed: %0d", errors, n_reqs);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verif/mem_model.sv
module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  delay,
    input  logic        mem_req_valid,
    input  logic [31:0] mem_req_addr,
    input  logic [31:0] mem_req_wdata,
    input  logic        mem_req_wr,
    output logic        mem_req_ready,
    output logic [31:0] mem_req_data
);

    logic [31:0] mem [logic [31:0]];
    logic        busy;
    logic [1:0]  count;
    logic [1:0]  wait_left;

    // unwritten words read back as the inverted address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr))
        begin
            return mem[addr];
        end
        return ~addr;
    endfunction

    assign wait_left = busy ? count : delay;

    initial
    begin
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
    end

    // responses change on the falling edge only
    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            busy          <= 1'b0;
            count         <= '0;
        end
        else if (mem_req_ready)
        begin
            mem_req_ready <= 1'b0;
            busy          <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (wait_left == 2'd0)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= read_word(mem_req_addr);
                if (mem_req_wr)
                begin
                    mem[mem_req_addr] = mem_req_wdata;
                end
            end
            else
            begin
                busy  <= 1'b1;
                count <= wait_left - 2'd1;
            end
        end
    end

endmodule

//--- design/cache_top.sv
module cache_top (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         cpu_req_valid,
    input  logic [cache_pkg::ADDR_W-1:0] cpu_req_addr,
    input  logic                         cpu_req_wr,
    input  logic [cache_pkg::DATA_W-1:0] cpu_req_wdata,
    output logic                         cpu_req_ready,
    output logic [cache_pkg::DATA_W-1:0] cpu_req_data,

    output logic                         mem_req_valid,
    output logic [cache_pkg::ADDR_W-1:0] mem_req_addr,
    output logic [cache_pkg::DATA_W-1:0] mem_req_wdata,
    output logic                         mem_req_wr,
    input  logic                         mem_req_ready,
    input  logic [cache_pkg::DATA_W-1:0] mem_req_data
);

    cache_pkg::cpu_req_t     req_q;
    cache_pkg::cache_state_e state;
    cache_pkg::line_t        line;
    cache_pkg::mem_req_t     mem_req;

    logic hit;
    logic victim_dirty;
    logic mem_done;
    logic array_write;
    logic array_fill;
    logic mem_start_wb;
    logic mem_start_fill;

    // request is captured once and held until completion
    always_ff @(posedge clk)
    begin
        if ((state == cache_pkg::st_idle) && cpu_req_valid)
        begin
            req_q.addr  <= cpu_req_addr;
            req_q.wr    <= cpu_req_wr;
            req_q.wdata <= cpu_req_wdata;
        end
    end

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .hit            (hit),
        .victim_dirty   (victim_dirty),
        .mem_done       (mem_done),
        .state          (state),
        .cpu_req_ready  (cpu_req_ready),
        .array_write    (array_write),
        .array_fill     (array_fill),
        .mem_start_wb   (mem_start_wb),
        .mem_start_fill (mem_start_fill)
    );

    cache_array u_array (
        .clk          (clk),
        .rst          (rst),
        .req          (req_q),
        .write        (array_write),
        .fill         (array_fill),
        .fill_data    (mem_req_data),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .line         (line)
    );

    mem_port u_mem (
        .clk           (clk),
        .rst           (rst),
        .start_wb      (mem_start_wb),
        .start_fill    (mem_start_fill),
        .req           (req_q),
        .victim        (line),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_done      (mem_done)
    );

    // writes echo the stored word back
    assign cpu_req_data = req_q.wr ? req_q.wdata : line.data;

    assign mem_req_addr  = mem_req.addr;
    assign mem_req_wdata = mem_req.wdata;
    assign mem_req_wr    = mem_req.wr;

endmodule

//--- design/mem_port.sv
module mem_port (
    input  logic                clk,
    input  logic                rst,

    input  logic                start_wb,
    input  logic                start_fill,

    input  cache_pkg::cpu_req_t req,
    input  cache_pkg::line_t    victim,

    input  logic                mem_req_ready,

    output cache_pkg::mem_req_t mem_req,
    output logic                mem_req_valid,
    output logic                mem_done
);

    localparam int PAD_W = cache_pkg::ADDR_W - cache_pkg::TAG_W - cache_pkg::INDEX_W;

    cache_pkg::mem_req_t req_q;
    logic                valid_q;
    logic [cache_pkg::ADDR_W-1:0] wb_addr;

    // evicted line lives at its own tag and the shared index
    assign wb_addr = {{PAD_W{1'b0}}, victim.tag, req.addr[cache_pkg::INDEX_W-1:0]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
        end
        else if (start_wb || start_fill)
        begin
            valid_q <= 1'b1;
        end
        else if (valid_q && mem_req_ready)
        begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_wb)
        begin
            req_q.addr  <= wb_addr;
            req_q.wdata <= victim.data;
            req_q.wr    <= 1'b1;
        end
        else if (start_fill)
        begin
            req_q.addr  <= req.addr;
            req_q.wdata <= '0;
            req_q.wr    <= 1'b0;
        end
    end

    assign mem_req       = req_q;
    assign mem_req_valid = valid_q;

    // completing cycle of the transfer
    assign mem_done = valid_q && mem_req_ready;

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

//--- design/cache_array.sv
module cache_array (
    input  logic                             clk,
    input  logic                             rst,

    input  cache_pkg::cpu_req_t              req,

    input  logic                             write,
    input  logic                             fill,
    input  logic [cache_pkg::DATA_W-1:0]     fill_data,

    output logic                             hit,
    output logic                             victim_dirty,
    output cache_pkg::line_t                 line
);

    logic [cache_pkg::NUM_SETS-1:0] valid_q;
    logic [cache_pkg::NUM_SETS-1:0] dirty_q;

    logic [cache_pkg::TAG_W-1:0]  tag_mem  [0:cache_pkg::NUM_SETS-1];
    logic [cache_pkg::DATA_W-1:0] data_mem [0:cache_pkg::NUM_SETS-1];

    logic [cache_pkg::INDEX_W-1:0] idx;
    logic [cache_pkg::TAG_W-1:0]   req_tag;
    logic                          cpu_wr;

    assign idx     = req.addr[cache_pkg::INDEX_W-1:0];
    assign req_tag = req.addr[cache_pkg::TAG_W+cache_pkg::INDEX_W-1:cache_pkg::INDEX_W];

    // a read hit commits nothing
    assign cpu_wr = write && !fill && req.wr;

    // control bits of every line
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (write && fill)
        begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end
        else if (cpu_wr)
        begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // tag and data storage
    always_ff @(posedge clk)
    begin
        if (write && fill)
        begin
            tag_mem[idx]  <= req_tag;
            data_mem[idx] <= fill_data;
        end
        else if (cpu_wr)
        begin
            data_mem[idx] <= req.wdata;
        end
    end

    // lookup of the indexed line
    always_comb
    begin
        line.valid = valid_q[idx];
        line.dirty = dirty_q[idx];
        line.tag   = tag_mem[idx];
        line.data  = data_mem[idx];
    end

    assign hit          = line.valid && (line.tag == req_tag);
    assign victim_dirty = line.valid && line.dirty;

    // high address bits are not part of the tag, so they must stay clear
    assert property (@(posedge clk) disable iff (rst)
        (write || fill) |->
            req.addr[cache_pkg::ADDR_W-1:cache_pkg::TAG_W+cache_pkg::INDEX_W] == '0);

endmodule

//--- design/cache_ctrl.sv
module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cpu_req_valid,

    input  logic                    hit,
    input  logic                    victim_dirty,
    input  logic                    mem_done,

    output cache_pkg::cache_state_e state,
    output logic                    cpu_req_ready,

    output logic                    array_write,
    output logic                    array_fill,

    output logic                    mem_start_wb,
    output logic                    mem_start_fill
);

    cache_pkg::cache_state_e state_q;
    cache_pkg::cache_state_e state_d;

    logic miss_clean;
    logic miss_dirty;
    logic fill_done;

    assign state = state_q;

    // decisions taken in compare_tag
    assign miss_clean = (state_q == cache_pkg::st_compare_tag) && !hit && !victim_dirty;
    assign miss_dirty = (state_q == cache_pkg::st_compare_tag) && !hit && victim_dirty;

    // fill word is on mem_req_data in the completing cycle
    assign fill_done = (state_q == cache_pkg::st_allocate) && mem_done;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= cache_pkg::st_idle;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            cache_pkg::st_idle:
            begin
                if (cpu_req_valid)
                begin
                    state_d = cache_pkg::st_compare_tag;
                end
            end
            cache_pkg::st_compare_tag:
            begin
                if (hit)
                begin
                    state_d = cache_pkg::st_idle;
                end
                else if (victim_dirty)
                begin
                    state_d = cache_pkg::st_write_back;
                end
                else
                begin
                    state_d = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_write_back:
            begin
                if (mem_done)
                begin
                    state_d = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_allocate:
            begin
                // retry the lookup that now hits
                if (mem_done)
                begin
                    state_d = cache_pkg::st_compare_tag;
                end
            end
            default:
            begin
                state_d = cache_pkg::st_idle;
            end
        endcase
    end

    // completion pulse doubles as the write hit commit
    assign cpu_req_ready = (state_q == cache_pkg::st_compare_tag) && hit;
    assign array_write   = cpu_req_ready || fill_done;
    assign array_fill    = fill_done;

    // start strobes are high in the first cycle of the wait state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_start_wb   <= 1'b0;
            mem_start_fill <= 1'b0;
        end
        else
        begin
            mem_start_wb   <= miss_dirty;
            mem_start_fill <= miss_clean ||
                              ((state_q == cache_pkg::st_write_back) && mem_done);
        end
    end

    // memory completions only while a transfer is awaited
    assert property (@(posedge clk) disable iff (rst)
        mem_done |-> (state_q == cache_pkg::st_write_back) ||
                     (state_q == cache_pkg::st_allocate));

    // a new transfer never starts on top of a completing one
    assert property (@(posedge clk) disable iff (rst)
        (mem_start_wb || mem_start_fill) |-> !mem_done);

endmodule

//--- design/cache_pkg.sv
package cache_pkg;

    // address and data widths on both ports
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // direct mapped geometry, one word per line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 12;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef enum logic [1:0] {
        st_idle,
        st_compare_tag,
        st_write_back,
        st_allocate
    } cache_state_e;

    // request as captured from the cpu port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    // request presented on the memory port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              wr;
    } mem_req_t;

    // one stored line, 46 bits
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } line_t;

endpackage
